//--- list.f
src/uart_pkg.sv
src/cmd_serializer.sv
src/uart_tx_framer.sv
src/uart_rx_deframer.sv
src/uart_bridge.sv
dv/tb_clk_gen.sv
dv/uart_bridge_tb.sv

//--- dv/uart_stimulus.txt
# cmd <word> <exp_hi> <exp_lo> | burst <count> | glitch <low clocks>
# inject <byte> <bad_parity> <bad_stop> <exp>, read words are {err, byte} in hex
cmd a55a 0a5 05a
cmd 0000 000 000
cmd ffff 0ff 0ff
cmd 1234 012 034
cmd 8001 080 001
burst 4
inject 3c 0 0 03c
inject 3c 1 0 13c
inject 3c 0 1 13c
inject a5 1 1 1a5
inject 00 0 0 000
inject ff 1 0 1ff
glitch 3
glitch 6
cmd c3e1 0c3 0e1
burst 3
inject 81 0 1 181
glitch 1
cmd 7f80 07f 080

//--- dv/uart_bridge_tb.sv
module uart_bridge_tb;

  localparam int CPB = 16;  // Clocks per bit

  logic                 clk;
  logic                 rst_n;
  uart_pkg::cmd_t       cmd_data;
  logic                 cmd_valid;
  logic                 cmd_ready;
  logic                 rx;
  logic                 tx;
  logic                 read_valid;
  uart_pkg::read_word_t read_data;

  logic                 loopback;  // rx from tx, else from the injector
  logic                 inj_rx;
  uart_pkg::byte_t      tx_exp[$];
  uart_pkg::read_word_t rd_exp[$];
  int                   val_errs = 0;
  int                   proto_errs = 0;
  int                   n_bytes = 0;
  int                   cycles = 0;
  int                   limit = 0;
  int                   seed = 78;

  tb_clk_gen #(.PERIOD(40), .RST_CYCLES(4)) tb_clk_gen_i (.clk(clk), .rst_n(rst_n));

  uart_bridge #(.CLKS_PER_BIT(CPB), .PARITY_EN(1'b1)) uart_bridge_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_data   (cmd_data),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .rx         (rx),
    .tx         (tx),
    .read_valid (read_valid),
    .read_data  (read_data)
  );

  assign rx = loopback ? tx : inj_rx;

  task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
      val_errs++;
    end
  endtask

  // Parity bit that makes the count of ones odd
  function automatic logic odd_parity(input uart_pkg::byte_t b);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      ones += b[i];
    end
    return (ones % 2 == 0);
  endfunction

  // Frame on tx, checked at mid-bit from the observed start edge
  initial begin
    uart_pkg::byte_t exp_byte;
    forever begin
      @(negedge tx);
      repeat (CPB / 2) @(posedge clk);
      @(negedge clk);
      assert (tx_exp.size() > 0) else begin
        $display("Frame started on tx at %0t with no byte pending", $time);
        proto_errs++;
      end
      exp_byte = (tx_exp.size() > 0) ? tx_exp.pop_front() : 8'h00;
      check_val("tx start bit", 16'd0, tx);
      for (int i = 0; i < 8; i++) begin
        repeat (CPB) @(negedge clk);
        check_val($sformatf("tx data bit %0d", i), exp_byte[i], tx);
      end
      repeat (CPB) @(negedge clk);
      check_val("tx parity bit", odd_parity(exp_byte), tx);  // Ones in data plus parity is odd
      repeat (CPB) @(negedge clk);
      check_val("tx stop bit", 16'd1, tx);
    end
  end

  always @(negedge clk) begin
    if (rst_n && read_valid) begin
      assert (rd_exp.size() > 0) else begin
        $display("Unexpected read_valid at %0t with read_data %h", $time, read_data);
        proto_errs++;
      end
      if (rd_exp.size() > 0) begin
        check_val("read_data", rd_exp.pop_front(), read_data);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout after %0d cycles, stimulus did not complete", cycles);
      $display("Errors %0d value, %0d protocol", val_errs, proto_errs);
      $display("Regression failed");
      $finish;
    end
  end

  // Bounded wait until every expected read word has arrived
  task automatic wait_reads();
    int n;
    n = 0;
    while (rd_exp.size() != 0 && n < 4 * 11 * CPB) begin
      @(posedge clk);
      n++;
    end
    assert (rd_exp.size() == 0) else begin
      $display("Missing read_valid, %0d read words never arrived", rd_exp.size());
      proto_errs++;
      rd_exp.delete();
    end
  endtask

  // Called just after a rising edge, returns just after the accepting edge
  task automatic send_cmd(input uart_pkg::cmd_t c, input uart_pkg::read_word_t e_hi,
                          input uart_pkg::read_word_t e_lo, output int waits);
    cmd_data  = c;
    cmd_valid = 1'b1;
    waits     = 0;
    @(negedge clk);
    while (!cmd_ready) begin
      waits++;
      @(negedge clk);
    end
    @(posedge clk);
    #5;
    tx_exp.push_back(c[15:8]);
    tx_exp.push_back(c[7:0]);
    rd_exp.push_back(e_hi);
    rd_exp.push_back(e_lo);
  endtask

  task automatic run_burst(input int count);
    uart_pkg::cmd_t c;
    int             waits;
    int             i;
    @(posedge clk);
    #5;
    loopback = 1'b1;
    for (i = 0; i < count; i++) begin
      c = 16'($random(seed));
      send_cmd(c, {1'b0, c[15:8]}, {1'b0, c[7:0]}, waits);  // Valid stays high
      if (i > 0) begin
        assert (waits > 0) else begin
          $display("cmd_ready never went low while burst command %0d waited", i);
          proto_errs++;
        end
      end
    end
    cmd_valid = 1'b0;
    wait_reads();
  endtask

  task automatic inject_frame(input uart_pkg::byte_t b, input bit bad_par, input bit bad_stop,
                              input uart_pkg::read_word_t exp);
    logic [10:0] frame;
    int          i;
    @(posedge clk);
    #5;
    loopback = 1'b0;
    rd_exp.push_back(exp);
    frame = {~bad_stop, odd_parity(b) ^ bad_par, b, 1'b0};  // Sent LSB first
    for (i = 0; i < 11; i++) begin
      inj_rx = frame[i];
      repeat (CPB) @(posedge clk);
      #5;
    end
    inj_rx = 1'b1;
    wait_reads();
  endtask

  // Short low pulse, then a quiet frame time
  task automatic inject_glitch(input int width);
    @(posedge clk);
    #5;
    loopback = 1'b0;
    inj_rx   = 1'b0;
    repeat (width) @(posedge clk);
    #5;
    inj_rx = 1'b1;
    repeat (11 * CPB) @(posedge clk);
  endtask

  // Dry pass only counts bytes for the timeout
  task automatic run_file(input bit dry);
    int                   fd;
    int                   code;
    int                   n;
    int                   waits;
    string                op;
    string                rest;
    uart_pkg::cmd_t       c;
    uart_pkg::read_word_t e0;
    uart_pkg::read_word_t e1;
    logic [7:0]           b;
    int                   bad_par;
    int                   bad_stop;
    fd = $fopen("dv/uart_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open dv/uart_stimulus.txt");
      proto_errs++;
    end else begin
      while ($fscanf(fd, "%s", op) == 1) begin
        if (op.substr(0, 0) == "#") begin
          code = $fgets(rest, fd);
        end else if (op == "cmd") begin
          code = $fscanf(fd, "%h %h %h", c, e0, e1);
          if (dry) begin
            n_bytes += 2;
          end else begin
            @(posedge clk);
            #5;
            loopback = 1'b1;
            send_cmd(c, e0, e1, waits);
            cmd_valid = 1'b0;
            wait_reads();
          end
        end else if (op == "burst") begin
          code = $fscanf(fd, "%d", n);
          if (dry) n_bytes += 2 * n;
          else run_burst(n);
        end else if (op == "inject") begin
          code = $fscanf(fd, "%h %d %d %h", b, bad_par, bad_stop, e0);
          if (dry) n_bytes += 1;
          else inject_frame(b, bad_par[0], bad_stop[0], e0);
        end else if (op == "glitch") begin
          code = $fscanf(fd, "%d", n);
          if (dry) n_bytes += 1;
          else inject_glitch(n);
        end else if (!dry) begin
          $display("Unknown operation %s in stimulus file", op);
          proto_errs++;
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    cmd_data  = '0;
    cmd_valid = 1'b0;
    loopback  = 1'b1;
    inj_rx    = 1'b1;
    run_file(1'b1);
    limit = n_bytes * 11 * CPB + 200;
    @(posedge rst_n);
    @(negedge clk);
    check_val("tx", 16'd1, tx);
    check_val("cmd_ready", 16'd1, cmd_ready);
    check_val("read_valid", 16'd0, read_valid);
    run_file(1'b0);
    assert (tx_exp.size() == 0) else begin
      $display("%0d bytes accepted on the command side never appeared on tx", tx_exp.size());
      proto_errs++;
    end
    $display("Errors %0d value, %0d protocol", val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- dv/tb_clk_gen.sv
module tb_clk_gen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #5;
    rst_n = 1'b1;  // Released just after an edge
  end

endmodule

//--- src/uart_bridge.sv
module uart_bridge #(
  parameter uart_pkg::baud_cnt_t CLKS_PER_BIT = 16'd16,
  parameter bit                  PARITY_EN    = 1'b1
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_pkg::cmd_t       cmd_data,
  input  logic                 cmd_valid,
  output logic                 cmd_ready,
  input  logic                 rx,
  output logic                 tx,
  output logic                 read_valid,
  output uart_pkg::read_word_t read_data
);

  // Serializer to framer handshake
  uart_pkg::byte_t byte_data;
  logic            byte_valid;
  logic            byte_ready;

  cmd_serializer cmd_serializer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_data   (cmd_data),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .byte_data  (byte_data),
    .byte_valid (byte_valid),
    .byte_ready (byte_ready)
  );

  uart_tx_framer #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .PARITY_EN    (PARITY_EN)
  ) uart_tx_framer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .byte_data  (byte_data),
    .byte_valid (byte_valid),
    .byte_ready (byte_ready),
    .tx         (tx)
  );

  // Receive side runs on its own, no link to the transmit path
  uart_rx_deframer #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .PARITY_EN    (PARITY_EN)
  ) uart_rx_deframer_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .read_valid (read_valid),
    .read_data  (read_data)
  );

endmodule

//--- src/uart_rx_deframer.sv
module uart_rx_deframer #(
  parameter uart_pkg::baud_cnt_t CLKS_PER_BIT = 16'd16,
  parameter bit                  PARITY_EN    = 1'b1
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  output logic                 read_valid,
  output uart_pkg::read_word_t read_data
);

  localparam uart_pkg::baud_cnt_t BIT_LAST  = CLKS_PER_BIT - 16'd1;
  localparam uart_pkg::baud_cnt_t HALF_LAST = (CLKS_PER_BIT >> 1) - 16'd1;

  uart_pkg::rx_state_t state;
  uart_pkg::baud_cnt_t baud_cnt;
  logic [2:0]          bit_idx;
  uart_pkg::byte_t     shift_q;
  logic                parity_q;
  logic                rx_meta;
  logic                rx_sync;
  logic                rx_prev;
  logic                start_edge;
  logic                sample;
  logic                frame_err;

  // Two-flop synchronizer plus one stage for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign start_edge = rx_prev && !rx_sync;

  // Start bit checked at half a period, later bits a full period apart
  assign sample = (state == uart_pkg::RX_START) ? (baud_cnt == HALF_LAST)
                                                : (baud_cnt == BIT_LAST);

  // Bad parity or a low stop bit
  assign frame_err = !rx_sync || (PARITY_EN && !(^{shift_q, parity_q}));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= uart_pkg::RX_IDLE;
      baud_cnt   <= '0;
      bit_idx    <= '0;
      read_valid <= 1'b0;
    end else begin
      read_valid <= 1'b0;

      if (state == uart_pkg::RX_IDLE || sample) begin
        baud_cnt <= '0;
      end else begin
        baud_cnt <= baud_cnt + 16'd1;
      end

      case (state)
        uart_pkg::RX_IDLE: begin
          if (start_edge) begin
            state <= uart_pkg::RX_START;
          end
        end
        uart_pkg::RX_START: begin
          if (sample) begin
            bit_idx <= '0;
            // High at midpoint is a glitch, drop it
            state   <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
          end
        end
        uart_pkg::RX_DATA: begin
          if (sample) begin
            if (bit_idx == 3'd7) begin
              state <= PARITY_EN ? uart_pkg::RX_PARITY : uart_pkg::RX_STOP;
            end else begin
              bit_idx <= bit_idx + 3'd1;
            end
          end
        end
        uart_pkg::RX_PARITY: begin
          if (sample) begin
            state <= uart_pkg::RX_STOP;
          end
        end
        uart_pkg::RX_STOP: begin
          if (sample) begin
            state      <= uart_pkg::RX_IDLE;
            read_valid <= 1'b1;
          end
        end
        default: begin
          state <= uart_pkg::RX_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sample) begin
      case (state)
        uart_pkg::RX_DATA:   shift_q   <= {rx_sync, shift_q[7:1]};  // LSB first
        uart_pkg::RX_PARITY: parity_q  <= rx_sync;
        uart_pkg::RX_STOP:   read_data <= {frame_err, shift_q};
        default: begin
        end
      endcase
    end
  end

  a_single_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    read_valid |=> !read_valid
  );

endmodule

//--- src/uart_tx_framer.sv
module uart_tx_framer #(
  parameter uart_pkg::baud_cnt_t CLKS_PER_BIT = 16'd16,
  parameter bit                  PARITY_EN    = 1'b1
) (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_pkg::byte_t byte_data,
  input  logic            byte_valid,
  output logic            byte_ready,
  output logic            tx
);

  localparam uart_pkg::baud_cnt_t BIT_LAST = CLKS_PER_BIT - 16'd1;

  uart_pkg::tx_state_t state;
  uart_pkg::baud_cnt_t baud_cnt;
  logic [2:0]          bit_idx;
  uart_pkg::byte_t     shift_q;
  logic                parity_q;
  logic                byte_take;
  logic                bit_done;

  assign byte_take = byte_valid && byte_ready;
  assign bit_done  = (baud_cnt == BIT_LAST);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= uart_pkg::TX_IDLE;
      baud_cnt   <= '0;
      bit_idx    <= '0;
      tx         <= 1'b1;  // Line idles high
      byte_ready <= 1'b1;
    end else begin
      if (state == uart_pkg::TX_IDLE || bit_done) begin
        baud_cnt <= '0;
      end else begin
        baud_cnt <= baud_cnt + 16'd1;
      end

      case (state)
        uart_pkg::TX_IDLE: begin
          if (byte_take) begin
            state      <= uart_pkg::TX_START;
            tx         <= 1'b0;
            byte_ready <= 1'b0;
          end
        end
        uart_pkg::TX_START: begin
          if (bit_done) begin
            state   <= uart_pkg::TX_DATA;
            bit_idx <= '0;
            tx      <= shift_q[0];
          end
        end
        uart_pkg::TX_DATA: begin
          if (bit_done) begin
            if (bit_idx == 3'd7) begin
              if (PARITY_EN) begin
                state <= uart_pkg::TX_PARITY;
                tx    <= parity_q;
              end else begin
                state <= uart_pkg::TX_STOP;
                tx    <= 1'b1;
              end
            end else begin
              bit_idx <= bit_idx + 3'd1;
              tx      <= shift_q[1];  // Next bit, before the shift lands
            end
          end
        end
        uart_pkg::TX_PARITY: begin
          if (bit_done) begin
            state <= uart_pkg::TX_STOP;
            tx    <= 1'b1;
          end
        end
        uart_pkg::TX_STOP: begin
          if (bit_done) begin
            state      <= uart_pkg::TX_IDLE;
            byte_ready <= 1'b1;
          end
        end
        default: begin
          state      <= uart_pkg::TX_IDLE;
          tx         <= 1'b1;
          byte_ready <= 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (byte_take) begin
      shift_q  <= byte_data;
      parity_q <= ~^byte_data;  // Odd parity
    end else if (state == uart_pkg::TX_DATA && bit_done) begin
      shift_q <= shift_q >> 1;
    end
  end

  a_idle_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    state == uart_pkg::TX_IDLE |-> tx
  );

  a_ready_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    byte_ready |-> state == uart_pkg::TX_IDLE
  );

endmodule

//--- src/cmd_serializer.sv
module cmd_serializer (
  input  logic              clk,
  input  logic              rst_n,
  input  uart_pkg::cmd_t    cmd_data,
  input  logic              cmd_valid,
  output logic              cmd_ready,
  output uart_pkg::byte_t   byte_data,
  output logic              byte_valid,
  input  logic              byte_ready
);

  localparam int CNT_W = $clog2(uart_pkg::CMD_BYTES + 1);

  logic [CNT_W-1:0] bytes_left;  // Bytes still to hand to the framer
  uart_pkg::cmd_t   cmd_q;
  logic             cmd_take;
  logic             byte_take;

  assign cmd_take  = cmd_valid && cmd_ready;
  assign byte_take = byte_valid && byte_ready;

  // Empty means ready for the next command
  assign cmd_ready  = (bytes_left == '0);
  assign byte_valid = (bytes_left != '0);

  // Current byte always sits at the top of the holding register
  assign byte_data = cmd_q[uart_pkg::CMD_W-1 -: uart_pkg::BYTE_W];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bytes_left <= '0;
    end else if (cmd_take) begin
      bytes_left <= CNT_W'(uart_pkg::CMD_BYTES);
    end else if (byte_take) begin
      bytes_left <= bytes_left - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_take) begin
      cmd_q <= cmd_data;
    end else if (byte_take) begin
      cmd_q <= cmd_q << uart_pkg::BYTE_W;  // Next byte moves up
    end
  end

  // Offered byte must not change while the framer is busy
  a_byte_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    byte_valid && !byte_ready |=> byte_valid && $stable(byte_data)
  );

endmodule

//--- src/uart_pkg.sv
package uart_pkg;

  localparam int BYTE_W = 8;
  localparam int CMD_W  = 16;

  // Bytes per command, high byte goes out first
  localparam int CMD_BYTES = CMD_W / BYTE_W;

  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [CMD_W-1:0]  cmd_t;

  // Error flag on top of the received byte
  typedef logic [BYTE_W:0]   read_word_t;

  typedef logic [15:0]       baud_cnt_t;  // Clocks within one bit

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP
  } tx_state_t;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_t;

endpackage
